/* sim.f */
hdl/procPkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/stallDetector.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/proc.sv
test/procTb.sv

/* Makefile */
# Verilator build and run of the core testbench
VERILATOR ?= verilator
TOP       ?= procTb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard hdl/*.sv) $(wildcard test/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) sim.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f sim.f

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/procTb.sv */
// Testbench for the five-stage core, checks every retirement against an ISA-level model
// Each test loads a program ROM during reset and runs until halted rises
// The data memory size must match dataMemWords of the DUT
`timescale 1ns/1ns

module procTb;

   localparam int dataMemWords = 64;
   localparam int romWords     = 128;

   logic        clk;
   logic        arstN;
   logic [15:0] instr;
   logic [15:0] instrAddr;
   logic        wbValid;
   logic [2:0]  wbReg;
   logic [15:0] wbData;
   logic        halted;
   logic        err;

   logic [15:0] rom [romWords];
   logic [15:0] prog [$];
   logic [2:0]  expRegQ [$];
   logic [15:0] expDataQ [$];
   int          errorCount;
   int          testCount;
   int          failedTests;
   int          totalWords;
   int          cycles;

   proc #(
      .dataMemWords (dataMemWords)
   ) u_proc (
      .clk       (clk),
      .arstN     (arstN),
      .instrAddr (instrAddr),
      .instr     (instr),
      .wbValid   (wbValid),
      .wbReg     (wbReg),
      .wbData    (wbData),
      .halted    (halted),
      .err       (err)
   );

   // Combinational ROM, NOP outside the program
   assign instr = (instrAddr < 16'(romWords)) ? rom[instrAddr[6:0]] : 16'h0;

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Budget grows as each test loads its program
   initial begin
      cycles = 0;
      while (cycles <= 16 + 12 * totalWords + 50) begin
         @(posedge clk);
         cycles = cycles + 1;
      end
      $display("Timeout after %0d cycles, the core never reached halted", cycles);
      $display("Simulation failed");
      $finish;
   end

   task automatic checkValue(input string name, input logic [15:0] got,
                             input logic [15:0] expected);
      if (got !== expected) begin
         $display("Fail %s: got 0x%h, expected 0x%h", name, got, expected);
         errorCount = errorCount + 1;
      end
   endtask

   function automatic logic [15:0] encodeR(input procPkg::opcodeT op, input logic [2:0] rd,
                                           input logic [2:0] rs, input logic [2:0] rt);
      return {op, rd, rs, rt, 3'b000};
   endfunction

   function automatic logic [15:0] encodeI(input procPkg::opcodeT op, input logic [2:0] rd,
                                           input logic [2:0] rs, input logic [5:0] imm);
      return {op, rd, rs, imm};
   endfunction

   // ISA-level model of the loaded ROM, returns the err outcome
   function automatic logic interpret();
      logic [15:0] regs [8];
      logic [15:0] mem [dataMemWords];
      logic [15:0] pc;
      logic [15:0] w;
      logic [15:0] imm;
      logic [2:0]  rd;
      logic [2:0]  rs;
      logic [2:0]  rt;
      int          idx;
      for (int i = 0; i < 8; i++) begin
         regs[i] = 16'h0;
      end
      for (int i = 0; i < dataMemWords; i++) begin
         mem[i] = 16'h0;
      end
      pc = 16'h0;
      for (int step = 0; step < 4096; step++) begin
         w   = (pc < 16'(romWords)) ? rom[pc[6:0]] : 16'h0;
         rd  = w[11:9];
         rs  = w[8:6];
         rt  = w[5:3];
         imm = {{10{w[5]}}, w[5:0]};
         idx = int'(regs[rs] + imm) % dataMemWords;
         pc  = pc + 16'd1;
         case (w[15:12])
            procPkg::opNop: ;
            procPkg::opAdd:  regs[rd] = regs[rs] + regs[rt];
            procPkg::opSub:  regs[rd] = regs[rs] - regs[rt];
            procPkg::opAnd:  regs[rd] = regs[rs] & regs[rt];
            procPkg::opXor:  regs[rd] = regs[rs] ^ regs[rt];
            procPkg::opAddi: regs[rd] = regs[rs] + imm;
            procPkg::opLd:   regs[rd] = mem[idx];
            procPkg::opSt:   mem[idx] = regs[rd];
            procPkg::opBeqz: begin
               if (regs[rs] == 16'h0) begin
                  pc = pc + imm;
               end
            end
            procPkg::opHalt: return 1'b0;
            default:         return 1'b1;
         endcase
         if (w[15:12] inside {[4'd1:4'd6]}) begin
            expRegQ.push_back(rd);
            expDataQ.push_back(regs[rd]);
         end
      end
      return 1'b0;
   endfunction

   task automatic loadRom();
      for (int i = 0; i < romWords; i++) begin
         rom[i] = (i < prog.size()) ? prog[i] : 16'h0;
      end
      totalWords = totalWords + prog.size();
   endtask

   // Compare each retirement with the model queue
   always @(negedge clk) begin
      if (arstN && wbValid) begin
         if (expRegQ.size() == 0) begin
            $display("Error: r%0d written with 0x%h after the last expected retirement",
                     wbReg, wbData);
            errorCount = errorCount + 1;
         end else begin
            checkValue("wbReg", 16'(wbReg), 16'(expRegQ[0]));
            checkValue("wbData", wbData, expDataQ[0]);
            void'(expRegQ.pop_front());
            void'(expDataQ.pop_front());
         end
      end
   end

   task automatic runTest(input string name, input logic expectErr);
      int   errorsBefore;
      logic modelErr;
      errorsBefore = errorCount;
      @(posedge clk);
      arstN <= 1'b0;
      loadRom();
      expRegQ.delete();
      expDataQ.delete();
      modelErr = interpret();
      repeat (15) @(posedge clk);
      @(negedge clk);
      checkValue("instrAddr", instrAddr, 16'h0);
      checkValue("wbValid", 16'(wbValid), 16'h0);
      checkValue("halted", 16'(halted), 16'h0);
      checkValue("err", 16'(err), 16'h0);
      @(posedge clk);
      arstN <= 1'b1;
      while (!halted) @(negedge clk);
      // Nothing may retire once the stop word has left memory
      repeat (8) begin
         @(negedge clk);
         checkValue("halted", 16'(halted), 16'h1);
      end
      if (expRegQ.size() != 0) begin
         $display("Error in %s: %0d expected register writes never retired",
                  name, expRegQ.size());
         errorCount = errorCount + 1;
      end
      if (modelErr !== expectErr) begin
         $display("Error in %s: the program does not end the way the test intends", name);
         errorCount = errorCount + 1;
      end
      checkValue("err", 16'(err), 16'(expectErr));
      testCount = testCount + 1;
      if (errorCount == errorsBefore) begin
         $display("Test %0d %s: ok", testCount, name);
      end else begin
         failedTests = failedTests + 1;
         $display("Test %0d %s: FAILED", testCount, name);
      end
   endtask

   // Random ALU chain, half the sources reuse the last destination
   task automatic buildAluChain(input int count);
      logic [31:0]     rnd;
      logic [2:0]      lastRd;
      logic [2:0]      rs;
      procPkg::opcodeT op;
      prog.delete();
      for (int r = 0; r < 8; r++) begin
         rnd = $urandom;
         prog.push_back(encodeI(procPkg::opAddi, 3'(r), 3'(r), rnd[5:0]));
      end
      lastRd = 3'd7;
      for (int i = 0; i < count; i++) begin
         rnd = $urandom;
         rs  = rnd[8] ? lastRd : rnd[14:12];
         case (int'(rnd[31:16] % 16'd5))
            0:       op = procPkg::opAdd;
            1:       op = procPkg::opSub;
            2:       op = procPkg::opAnd;
            3:       op = procPkg::opXor;
            default: op = procPkg::opAddi;
         endcase
         if (op == procPkg::opAddi) begin
            prog.push_back(encodeI(op, rnd[2:0], rs, rnd[11:6]));
         end else begin
            prog.push_back(encodeR(op, rnd[2:0], rs, rnd[5:3]));
         end
         lastRd = rnd[2:0];
      end
      prog.push_back(encodeR(procPkg::opHalt, 0, 0, 0));
   endtask

   // r1 sits near the top of data memory so offsets wrap
   task automatic buildMemory();
      logic [31:0] rnd;
      prog.delete();
      prog.push_back(encodeI(procPkg::opAddi, 1, 7, 31));
      prog.push_back(encodeI(procPkg::opAddi, 1, 1, 31));
      prog.push_back(encodeI(procPkg::opAddi, 2, 7, 6'(-7)));
      prog.push_back(encodeI(procPkg::opSt, 2, 1, 1));
      prog.push_back(encodeI(procPkg::opSt, 1, 1, 3));
      prog.push_back(encodeI(procPkg::opLd, 3, 1, 1));
      prog.push_back(encodeI(procPkg::opLd, 4, 7, 1));
      for (int i = 0; i < 6; i++) begin
         rnd = $urandom;
         prog.push_back(encodeI(procPkg::opAddi, 2, 7, rnd[5:0]));
         prog.push_back(encodeI(procPkg::opSt, 2, 1, rnd[11:6]));
         prog.push_back(encodeI(procPkg::opLd, 3, 1, rnd[11:6]));
      end
      prog.push_back(encodeI(procPkg::opLd, 5, 7, 60));
      prog.push_back(encodeR(procPkg::opHalt, 0, 0, 0));
   endtask

   // Countdown loop, words 4 and 5 follow taken branches
   task automatic buildBranch();
      prog.delete();
      prog.push_back(encodeI(procPkg::opAddi, 1, 7, 3));
      prog.push_back(encodeI(procPkg::opAddi, 2, 2, 5));
      prog.push_back(encodeI(procPkg::opAddi, 1, 1, 6'(-1)));
      prog.push_back(encodeI(procPkg::opBeqz, 0, 1, 2));
      prog.push_back(encodeI(procPkg::opBeqz, 0, 7, 6'(-4)));
      prog.push_back(encodeI(procPkg::opAddi, 6, 7, 31));
      prog.push_back(encodeI(procPkg::opAddi, 3, 2, 1));
      prog.push_back(encodeR(procPkg::opHalt, 0, 0, 0));
   endtask

   task automatic buildStop(input logic illegal);
      prog.delete();
      prog.push_back(encodeI(procPkg::opAddi, 1, 7, 9));
      prog.push_back(encodeI(procPkg::opAddi, 2, 1, 6'(-3)));
      if (illegal) begin
         prog.push_back({4'hb, 3'd2, 3'd7, 6'd0});
      end else begin
         prog.push_back(encodeR(procPkg::opHalt, 0, 0, 0));
      end
      prog.push_back(encodeI(procPkg::opAddi, 3, 7, 1));
      prog.push_back(encodeR(procPkg::opAdd, 4, 1, 2));
      prog.push_back(encodeR(procPkg::opHalt, 0, 0, 0));
   endtask

   initial begin
      void'($urandom(32'h9a17_011a));
      arstN       = 1'b0;
      errorCount  = 0;
      testCount   = 0;
      failedTests = 0;
      totalWords  = 0;
      prog.delete();
      loadRom();

      prog.delete();
      prog.push_back(encodeI(procPkg::opAddi, 5, 7, 12));
      prog.push_back(encodeI(procPkg::opAddi, 6, 5, 6'(-2)));
      prog.push_back(encodeR(procPkg::opHalt, 0, 0, 0));
      runTest("reset state", 1'b0);
      buildAluChain(30);
      runTest("alu chain", 1'b0);
      buildMemory();
      runTest("store and load", 1'b0);
      buildBranch();
      runTest("branch", 1'b0);
      buildStop(1'b0);
      runTest("halt", 1'b0);
      buildStop(1'b1);
      runTest("illegal opcode", 1'b1);

      $display("%0d tests run, %0d failed, %0d check errors",
               testCount, failedTests, errorCount);
      if (errorCount == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* hdl/proc.sv */
// Top level of the 16-bit five-stage in-order core
// instr must return the word at instrAddr in the same cycle
// wbValid marks each register write in program order
// halted and err hold until reset; there is no back-pressure
`timescale 1ns/1ns

module proc #(
   parameter int dataMemWords = 64
) (
   input  logic        clk,
   input  logic        arstN,
   output logic [15:0] instrAddr,
   input  logic [15:0] instr,
   output logic        wbValid,
   output logic [2:0]  wbReg,
   output logic [15:0] wbData,
   output logic        halted,
   output logic        err
);

   procPkg::ifIdT  ifId;
   procPkg::idExT  idEx;
   procPkg::exMemT exMem;
   procPkg::memWbT memWb;

   logic        stall;
   logic        redirect;
   logic [15:0] redirectPc;
   logic        haltSeen;
   logic        haltedReg;
   logic        errReg;

   fetchStage u_fetch (
      .clk        (clk),
      .arstN      (arstN),
      .stall      (stall),
      .redirect   (redirect),
      .redirectPc (redirectPc),
      .haltSeen   (haltSeen),
      .instr      (instr),
      .instrAddr  (instrAddr),
      .ifId       (ifId)
   );

   decodeStage u_decode (
      .clk        (clk),
      .arstN      (arstN),
      .ifId       (ifId),
      .stall      (stall),
      .memWb      (memWb),
      .idEx       (idEx),
      .redirect   (redirect),
      .redirectPc (redirectPc),
      .haltSeen   (haltSeen)
   );

   stallDetector u_stall (
      .ifId  (ifId),
      .idEx  (idEx),
      .exMem (exMem),
      .stall (stall)
   );

   executeStage u_execute (
      .clk   (clk),
      .arstN (arstN),
      .idEx  (idEx),
      .exMem (exMem)
   );

   memoryStage #(
      .dataMemWords (dataMemWords)
   ) u_memory (
      .clk   (clk),
      .arstN (arstN),
      .exMem (exMem),
      .memWb (memWb)
   );

   // Retire port, only register writes show up
   assign wbValid = memWb.valid;
   assign wbReg   = memWb.dst;
   assign wbData  = memWb.data;

   // Flags rise as the stop word leaves memory, then stick
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         haltedReg <= 1'b0;
         errReg    <= 1'b0;
      end else begin
         if (memWb.halt || memWb.illegal) begin
            haltedReg <= 1'b1;
         end
         if (memWb.illegal) begin
            errReg <= 1'b1;
         end
      end
   end

   assign halted = haltedReg || memWb.halt || memWb.illegal;
   assign err    = errReg || memWb.illegal;

endmodule

/* hdl/memoryStage.sv */
// Memory stage with data memory and MEM/WB register
// dataMemWords must be a power of two, at least 2; addresses wrap
// Data memory clears on reset, loads read it in the same cycle
`timescale 1ns/1ns

module memoryStage #(
   parameter int dataMemWords = 64
) (
   input  logic           clk,
   input  logic           arstN,
   input  procPkg::exMemT exMem,
   output procPkg::memWbT memWb
);

   localparam int addrBits = $clog2(dataMemWords);

   logic [15:0]          dataMem [dataMemWords];
   logic [addrBits-1:0]  addr;
   logic [15:0]          loadData;
   procPkg::memWbT       nextWb;

   assign addr     = exMem.result[addrBits-1:0];
   assign loadData = dataMem[addr];

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < dataMemWords; i++) begin
            dataMem[i] <= '0;
         end
      end else if (exMem.store) begin
         dataMem[addr] <= exMem.stData;
      end
   end

   always_comb begin
      nextWb.valid   = exMem.wrReg;
      nextWb.dst     = exMem.dst;
      nextWb.data    = exMem.load ? loadData : exMem.result;
      nextWb.halt    = exMem.halt;
      nextWb.illegal = exMem.illegal;
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         memWb <= '0;
      end else begin
         memWb <= nextWb;
      end
   end

   // Decode never marks a stop word as a register write
   assert property (@(posedge clk) disable iff (!arstN)
      exMem.wrReg |-> !(exMem.halt || exMem.illegal));

endmodule

/* hdl/executeStage.sv */
// Execute stage with ALU and EX/MEM register
// LD and ST share the add path for the address
// Control bits leaving this stage are already qualified by valid
`timescale 1ns/1ns

module executeStage (
   input  logic           clk,
   input  logic           arstN,
   input  procPkg::idExT  idEx,
   output procPkg::exMemT exMem
);

   logic [15:0]    aluOut;
   procPkg::exMemT nextMem;

   always_comb begin
      case (idEx.op)
         procPkg::opSub: aluOut = idEx.opA - idEx.opB;
         procPkg::opAnd: aluOut = idEx.opA & idEx.opB;
         procPkg::opXor: aluOut = idEx.opA ^ idEx.opB;
         // ADD, ADDI and the LD/ST address
         default:        aluOut = idEx.opA + idEx.opB;
      endcase
   end

   always_comb begin
      nextMem.valid   = idEx.valid;
      nextMem.wrReg   = idEx.valid && idEx.wrReg;
      nextMem.load    = idEx.valid && idEx.op == procPkg::opLd;
      nextMem.store   = idEx.valid && idEx.op == procPkg::opSt;
      nextMem.halt    = idEx.valid && idEx.op == procPkg::opHalt;
      nextMem.illegal = idEx.valid && idEx.illegal;
      nextMem.dst     = idEx.dst;
      nextMem.result  = aluOut;
      nextMem.stData  = idEx.stData;
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         exMem <= '0;
      end else begin
         exMem <= nextMem;
      end
   end

   // A load always writes its register and a store never does
   assert property (@(posedge clk) disable iff (!arstN)
      exMem.valid && (exMem.load || exMem.store) |-> exMem.wrReg == exMem.load);

endmodule

/* hdl/stallDetector.sv */
// Read-after-write check for the word in IF/ID
// Only ID/EX and EX/MEM are checked; MEM/WB is covered by write-through
`timescale 1ns/1ns

module stallDetector (
   input  procPkg::ifIdT  ifId,
   input  procPkg::idExT  idEx,
   input  procPkg::exMemT exMem,
   output logic           stall
);

   logic readsRs;
   logic readsRt;
   logic readsRd;

   // Register still being produced further down
   function automatic logic inFlight(input logic [2:0] idx);
      return (idEx.valid && idEx.wrReg && idEx.dst == idx) ||
             (exMem.valid && exMem.wrReg && exMem.dst == idx);
   endfunction

   always_comb begin
      readsRs = 1'b0;
      readsRt = 1'b0;
      readsRd = 1'b0;
      case (ifId.instr.rForm.opcode)
         procPkg::opAdd, procPkg::opSub, procPkg::opAnd, procPkg::opXor: begin
            readsRs = 1'b1;
            readsRt = 1'b1;
         end
         procPkg::opAddi, procPkg::opLd, procPkg::opBeqz: begin
            readsRs = 1'b1;
         end
         procPkg::opSt: begin
            readsRs = 1'b1;
            readsRd = 1'b1;
         end
         default: ;
      endcase

      stall = ifId.valid &&
              ((readsRs && inFlight(ifId.instr.rForm.rs)) ||
               (readsRt && inFlight(ifId.instr.rForm.rt)) ||
               (readsRd && inFlight(ifId.instr.rForm.rd)));
   end

endmodule

/* hdl/decodeStage.sv */
// Decode stage with register file, branch resolution and ID/EX register
// No forwarding; the register file writes through to same-cycle reads
// BEQZ is resolved here, a taken branch costs one bubble
// HALT and illegal words latch haltSeen until reset
`timescale 1ns/1ns

module decodeStage (
   input  logic           clk,
   input  logic           arstN,
   input  procPkg::ifIdT  ifId,
   input  logic           stall,
   input  procPkg::memWbT memWb,
   output procPkg::idExT  idEx,
   output logic           redirect,
   output logic [15:0]    redirectPc,
   output logic           haltSeen
);

   logic [15:0]    regs [8];
   logic [15:0]    rsVal;
   logic [15:0]    rtVal;
   logic [15:0]    rdVal;
   logic [15:0]    immExt;
   logic           isStop;
   logic           branchTaken;
   logic           haltLatched;
   procPkg::idExT  decoded;

   // Write-through so a retiring value is seen in this cycle
   function automatic logic [15:0] readReg(input logic [2:0] idx);
      if (memWb.valid && memWb.dst == idx) begin
         return memWb.data;
      end
      return regs[idx];
   endfunction

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (memWb.valid) begin
         regs[memWb.dst] <= memWb.data;
      end
   end

   always_comb begin
      rsVal  = readReg(ifId.instr.rForm.rs);
      rtVal  = readReg(ifId.instr.rForm.rt);
      rdVal  = readReg(ifId.instr.rForm.rd);
      immExt = {{10{ifId.instr.iForm.imm[5]}}, ifId.instr.iForm.imm};

      decoded         = '0;
      decoded.op      = ifId.instr.rForm.opcode;
      decoded.dst     = ifId.instr.rForm.rd;
      decoded.opA     = rsVal;
      decoded.opB     = rtVal;
      decoded.stData  = rdVal;
      isStop          = 1'b0;
      branchTaken     = 1'b0;

      case (ifId.instr.rForm.opcode)
         procPkg::opNop: ;
         procPkg::opAdd, procPkg::opSub, procPkg::opAnd, procPkg::opXor: begin
            decoded.wrReg = 1'b1;
         end
         procPkg::opAddi, procPkg::opLd: begin
            decoded.wrReg = 1'b1;
            decoded.opB   = immExt;
         end
         procPkg::opSt: begin
            decoded.opB = immExt;
         end
         procPkg::opBeqz: begin
            branchTaken = (rsVal == 16'd0);
         end
         procPkg::opHalt: begin
            isStop = 1'b1;
         end
         default: begin
            decoded.illegal = 1'b1;
            isStop          = 1'b1;
         end
      endcase

      // Stalled words go down as bubbles
      decoded.valid = ifId.valid && !stall;
   end

   assign redirect   = ifId.valid && !stall && branchTaken;
   assign redirectPc = ifId.pc + 16'd1 + immExt;
   assign haltSeen   = haltLatched || (ifId.valid && isStop);

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         haltLatched <= 1'b0;
         idEx        <= '0;
      end else begin
         if (ifId.valid && isStop) begin
            haltLatched <= 1'b1;
         end
         idEx <= decoded;
      end
   end

   // Nothing retires out of a pipeline held in reset
   assert property (@(posedge clk) !arstN |-> !memWb.valid);

endmodule

/* hdl/fetchStage.sv */
// Fetch stage with PC and IF/ID register
// Instruction memory is external and read in the same cycle
// Redirect wins over stall; once haltSeen is high only bubbles leave
`timescale 1ns/1ns

module fetchStage (
   input  logic           clk,
   input  logic           arstN,
   input  logic           stall,
   input  logic           redirect,
   input  logic [15:0]    redirectPc,
   input  logic           haltSeen,
   input  logic [15:0]    instr,
   output logic [15:0]    instrAddr,
   output procPkg::ifIdT  ifId
);

   logic [15:0]   pc;
   procPkg::ifIdT fetched;

   assign instrAddr = pc;

   always_comb begin
      fetched.valid = 1'b1;
      fetched.pc    = pc;
      fetched.instr = instr;
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc   <= '0;
         ifId <= '0;
      end else if (redirect) begin
         // Word fetched this cycle is on the wrong path
         pc         <= redirectPc;
         ifId.valid <= 1'b0;
      end else if (haltSeen) begin
         ifId.valid <= 1'b0;
      end else if (!stall) begin
         pc   <= pc + 16'd1;
         ifId <= fetched;
      end
   end

   // Decode never resolves a branch it is stalling on
   assert property (@(posedge clk) disable iff (!arstN) !(stall && redirect));

endmodule

/* hdl/procPkg.sv */
// Shared types for the 16-bit five-stage core
// Words are 16 bits and the PC counts words, not bytes
// Opcodes outside opcodeT are illegal and stop the core like HALT
package procPkg;

   typedef enum logic [3:0] {
      opNop  = 4'd0,
      opAdd  = 4'd1,
      opSub  = 4'd2,
      opAnd  = 4'd3,
      opXor  = 4'd4,
      opAddi = 4'd5,
      opLd   = 4'd6,
      opSt   = 4'd7,
      opBeqz = 4'd8,
      opHalt = 4'd15
   } opcodeT;

   // Register form, three register fields
   typedef struct packed {
      opcodeT     opcode;
      logic [2:0] rd;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] unused;
   } rFormT;

   // Immediate form, imm is two's complement
   typedef struct packed {
      opcodeT            opcode;
      logic [2:0]        rd;
      logic [2:0]        rs;
      logic signed [5:0] imm;
   } iFormT;

   typedef union packed {
      rFormT rForm;
      iFormT iForm;
   } instrWordT;

   typedef struct packed {
      logic       valid;
      logic [15:0] pc;
      instrWordT  instr;
   } ifIdT;

   typedef struct packed {
      logic        valid;
      opcodeT      op;
      logic [2:0]  dst;
      logic        wrReg;
      logic [15:0] opA;
      logic [15:0] opB;
      logic [15:0] stData;
      logic        illegal;
   } idExT;

   typedef struct packed {
      logic        valid;
      logic        wrReg;
      logic        load;
      logic        store;
      logic        halt;
      logic        illegal;
      logic [2:0]  dst;
      logic [15:0] result;
      logic [15:0] stData;
   } exMemT;

   // valid here means a register write
   typedef struct packed {
      logic        valid;
      logic [2:0]  dst;
      logic [15:0] data;
      logic        halt;
      logic        illegal;
   } memWbT;

endpackage
